/* compile.f */
src/vec_pkg.sv
src/vec_lane_if.sv
src/vec_row_counter.sv
src/vec_lane.sv
src/vec_reduction.sv
src/vec_sequencer.sv
src/vec_unit.sv
tb/tb_vec_unit.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the vector unit testbench with Verilator and runs it.
# Exits with a non-zero status unless the log shows a passing run.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_vec_unit -Mdir "$BUILD_DIR" -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_vec_unit" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "RESULT: PASS" "$LOG"; then
  exit 0
fi
echo "Simulation did not pass, see $LOG"
exit 1

/* src/vec_lane.sv */
// One vector lane.
// Holds this lane's slice of every vector register (one element per
// row), runs the element ALU on the current row and writes vd at the
// edge that ends the row. Its vs2 element goes to the reduction.
// LANE_ID sets the lane's position in the element numbering.

`timescale 1ns/1ns

module vec_lane #(
  parameter int unsigned LANE_ID = 0
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  vec_lane_if.lane_mp lane_if
);
  import vec_pkg::*;

  elem_t regs_q [NR_VREGS][ROWS];
  elem_t src1;
  elem_t src2;
  elem_t wr_data;
  logic  writes_vd;
  logic  wr_en;

  //////////////////////////////////////////////////////////////////////
  // Operand read
  //////////////////////////////////////////////////////////////////////

  assign src1 = regs_q[lane_if.vs1][lane_if.row];
  assign src2 = regs_q[lane_if.vs2][lane_if.row];

  //////////////////////////////////////////////////////////////////////
  // Element ALU
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wr_data   = '0;
    writes_vd = 1'b1;
    case (lane_if.op)
      VADD:   wr_data = src1 + src2;
      VSUB:   wr_data = src2 - src1;
      VAND:   wr_data = src1 & src2;
      VXOR:   wr_data = src1 ^ src2;
      VBCAST: wr_data = lane_if.imm;
      // Element index across all lanes
      VID:    wr_data = elem_t'(int'(lane_if.row) * NR_LANES + LANE_ID);
      // Reduction only reads, the rest are no-ops
      default: writes_vd = 1'b0;
    endcase
  end

  assign wr_en = lane_if.row_valid && writes_vd;

  //////////////////////////////////////////////////////////////////////
  // Register slice
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      regs_q[lane_if.vd][lane_if.row] <= wr_data;
    end
  end

  assign lane_if.lane_elem[LANE_ID] = src2;

  // Rows of one instruction arrive in order and each is written once
  a_row_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (lane_if.row_valid && lane_if.row != row_t'(ROWS - 1))
      |=> (lane_if.row_valid && lane_if.row == $past(lane_if.row) + row_t'(1)));

endmodule

/* src/vec_lane_if.sv */
// Row command from the sequencer to the lanes, and the per-lane
// vs2 element of the current row going to the reduction.
// One instance lives in the top level and every block takes its modport.

`timescale 1ns/1ns

interface vec_lane_if;
  import vec_pkg::*;

  // Driven by the sequencer
  logic    row_valid;
  vec_op_e op;
  vreg_t   vd;
  vreg_t   vs1;
  vreg_t   vs2;
  elem_t   imm;
  row_t    row;

  // One slot per lane, each lane drives its own
  elem_t   lane_elem [NR_LANES];

  modport seq_mp (
    output row_valid, op, vd, vs1, vs2, imm, row
  );

  modport lane_mp (
    input  row_valid, op, vd, vs1, vs2, imm, row,
    output lane_elem
  );

  modport red_mp (
    input row_valid, op, lane_elem
  );

endinterface

/* src/vec_pkg.sv */
// Shared definitions for the vector coprocessor.
// Holds the lane geometry, the opcode encoding and the two views of the
// 32-bit instruction word. Modules import it inside their bodies and
// use scoped names in their port lists.

package vec_pkg;

  //////////////////////////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NR_LANES = 4;
  // Elements of one register held by each lane
  localparam int unsigned ROWS     = 4;
  localparam int unsigned NR_VREGS = 8;
  localparam int unsigned ELEM_W   = 16;
  // Wide enough for the sum of all 16 elements
  localparam int unsigned SUM_W    = 20;

  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;
  typedef logic [$clog2(ROWS)-1:0]     row_t;
  typedef logic [ELEM_W-1:0]           elem_t;
  typedef logic [SUM_W-1:0]            sum_t;

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////

  // Codes not listed here execute as no-ops.
  // VSUB follows the RVV order: vd = vs2 - vs1
  typedef enum logic [3:0] {
    VADD    = 4'h1,
    VSUB    = 4'h2,
    VAND    = 4'h3,
    VXOR    = 4'h4,
    VBCAST  = 4'h5,
    VID     = 4'h6,
    VREDSUM = 4'h7
  } vec_op_e;

  // Register-register view
  typedef struct packed {
    vec_op_e     op;
    vreg_t       vd;
    vreg_t       vs1;
    vreg_t       vs2;
    logic [18:0] rsvd;
  } vec_insn_arith_t;

  // Immediate view, only read by VBCAST
  typedef struct packed {
    vec_op_e    op;
    vreg_t      vd;
    elem_t      imm;
    logic [8:0] rsvd;
  } vec_insn_imm_t;

  typedef union packed {
    vec_insn_arith_t arith;
    vec_insn_imm_t   bcast;
  } vec_insn_u;

endpackage

/* src/vec_reduction.sv */
// Cross-lane reduction for VREDSUM.
// Adds the vs2 elements of all lanes for each row and accumulates them
// over the rows of one instruction. The total stays on sum_o until the
// next clear, which the sequencer issues at the start of an instruction.

`timescale 1ns/1ns

module vec_reduction (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          clear_i,
  vec_lane_if.red_mp    lane_if,
  output vec_pkg::sum_t sum_o
);
  import vec_pkg::*;

  sum_t row_sum;
  sum_t acc_q;

  // Adder tree over the lanes, zero-extended to the sum width
  always_comb begin
    row_sum = '0;
    for (int l = 0; l < NR_LANES; l++) begin
      row_sum = row_sum + sum_t'(lane_if.lane_elem[l]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;
    end else if (lane_if.row_valid && lane_if.op == VREDSUM) begin
      acc_q <= acc_q + row_sum;
    end
  end

  assign sum_o = acc_q;

  // Total of one instruction fits in SUM_W bits
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (lane_if.row_valid && lane_if.op == VREDSUM && !clear_i)
      |-> (sum_t'(acc_q + row_sum) >= acc_q));

endmodule

/* src/vec_row_counter.sv */
// Row counter that paces an instruction through the element rows.
// Cleared by start, advanced once per cycle while run is high, and
// flags the last row so the sequencer can finish.

`timescale 1ns/1ns

module vec_row_counter (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          start_i,
  input  logic          run_i,
  output vec_pkg::row_t row_o,
  output logic          last_o
);
  import vec_pkg::*;

  row_t row_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      row_q <= '0;
    end else if (start_i) begin
      row_q <= '0;
    end else if (run_i && !last_o) begin
      row_q <= row_q + row_t'(1);
    end
  end

  assign row_o  = row_q;
  assign last_o = (row_q == row_t'(ROWS - 1));

  // Run ends on the last row so the count never wraps
  a_stop_at_last: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (run_i && last_o) |=> !run_i);

endmodule

/* src/vec_sequencer.sv */
// Instruction sequencer of the vector unit.
// Accepts one instruction at a time over a valid/ready request port,
// starts the row counter, drives one row command per cycle to the lanes
// and raises a one-cycle scalar response when the last row is done.

`timescale 1ns/1ns

module vec_sequencer (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Request from the scalar core
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  vec_pkg::vec_insn_u req_insn_i,
  // Row counter
  output logic               cnt_start_o,
  output logic               cnt_run_o,
  input  vec_pkg::row_t      cnt_row_i,
  input  logic               cnt_last_i,
  // Reduction total
  input  vec_pkg::sum_t      red_sum_i,
  // Scalar response
  output logic               resp_valid_o,
  output vec_pkg::sum_t      resp_data_o,
  vec_lane_if.seq_mp         lane_if
);
  import vec_pkg::*;

  // EXEC covers the start cycle and rows 0 to ROWS-2, RESP the last row
  typedef enum logic [1:0] {IDLE, EXEC, RESP} state_e;

  state_e    state_q;
  logic      run_q;
  logic      resp_valid_q;
  vec_insn_u insn_q;
  vec_op_e   op;
  logic      accept;

  assign req_ready_o = (state_q == IDLE);
  assign accept      = req_valid_i && req_ready_o;

  //////////////////////////////////////////////////////////////////////
  // Control FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= IDLE;
      run_q        <= 1'b0;
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= EXEC;
          end
        end
        EXEC: begin
          // First cycle only clears counter and accumulator
          if (!run_q) begin
            run_q <= 1'b1;
          end else if (cnt_row_i == row_t'(ROWS - 2)) begin
            state_q <= RESP;
          end
        end
        RESP: begin
          if (cnt_last_i) begin
            state_q      <= IDLE;
            run_q        <= 1'b0;
            resp_valid_q <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Instruction is held for the whole run
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= req_insn_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Decode and row command
  //////////////////////////////////////////////////////////////////////

  assign op = insn_q.arith.op;

  always_comb begin
    lane_if.op  = op;
    lane_if.vd  = insn_q.arith.vd;
    lane_if.vs1 = insn_q.arith.vs1;
    lane_if.vs2 = insn_q.arith.vs2;
    lane_if.imm = '0;
    // Broadcast carries an immediate where the sources would be
    if (op == VBCAST) begin
      lane_if.vd  = insn_q.bcast.vd;
      lane_if.vs1 = '0;
      lane_if.vs2 = '0;
      lane_if.imm = insn_q.bcast.imm;
    end
  end

  assign lane_if.row_valid = run_q;
  assign lane_if.row       = cnt_row_i;
  assign cnt_start_o       = (state_q == EXEC) && !run_q;
  assign cnt_run_o         = run_q;

  // Only VREDSUM returns data
  assign resp_valid_o = resp_valid_q;
  assign resp_data_o  = (resp_valid_q && op == VREDSUM) ? red_sum_i : '0;

  // Busy from acceptance until the response cycle
  a_busy_window: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |=> !req_ready_o ##1 !req_ready_o ##1 !req_ready_o ##1 !req_ready_o
      ##1 !req_ready_o ##1 (req_ready_o && resp_valid_o));

endmodule

/* src/vec_unit.sv */
// Top level of the vector coprocessor.
// A scalar core sends 32-bit vector instructions over a valid/ready
// port. Each instruction runs over all rows of the four lanes and
// ends with a one-cycle response carrying the VREDSUM total, or zero.

`timescale 1ns/1ns

module vec_unit (
  input  logic          clk_i,
  input  logic          rst_n_i,
  // Instruction request
  input  logic          req_valid_i,
  output logic          req_ready_o,
  input  logic [31:0]   req_insn_i,
  // Scalar response, no back-pressure
  output logic          resp_valid_o,
  output vec_pkg::sum_t resp_data_o
);
  import vec_pkg::*;

  logic cnt_start;
  logic cnt_run;
  row_t cnt_row;
  logic cnt_last;
  sum_t red_sum;

  vec_lane_if lane_if ();

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////

  vec_sequencer i_sequencer (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .req_valid_i  (req_valid_i ),
    .req_ready_o  (req_ready_o ),
    .req_insn_i   (req_insn_i  ),
    .cnt_start_o  (cnt_start   ),
    .cnt_run_o    (cnt_run     ),
    .cnt_row_i    (cnt_row     ),
    .cnt_last_i   (cnt_last    ),
    .red_sum_i    (red_sum     ),
    .resp_valid_o (resp_valid_o),
    .resp_data_o  (resp_data_o ),
    .lane_if      (lane_if     )
  );

  vec_row_counter i_row_counter (
    .clk_i   (clk_i    ),
    .rst_n_i (rst_n_i  ),
    .start_i (cnt_start),
    .run_i   (cnt_run  ),
    .row_o   (cnt_row  ),
    .last_o  (cnt_last )
  );

  //////////////////////////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////////////////////////

  for (genvar l = 0; l < NR_LANES; l++) begin : gen_lanes
    vec_lane #(
      .LANE_ID (l)
    ) i_lane (
      .clk_i   (clk_i  ),
      .rst_n_i (rst_n_i),
      .lane_if (lane_if)
    );
  end

  vec_reduction i_reduction (
    .clk_i   (clk_i    ),
    .rst_n_i (rst_n_i  ),
    .clear_i (cnt_start),
    .lane_if (lane_if  ),
    .sum_o   (red_sum  )
  );

endmodule

/* tb/tb_vec_unit.sv */
// Self-checking testbench for the vector coprocessor top level.
// Sends instruction sequences through the request port, keeps a model
// of all vector registers and checks handshake timing and response data
// with concurrent assertions. Immediates come from a Galois LFSR.

`timescale 1ns/1ns

module tb_vec_unit;
  import vec_pkg::*;

  localparam int unsigned ELEMS      = NR_LANES * ROWS;
  localparam int unsigned CLK_PERIOD = 10;
  // Instructions sent by the test sequence below
  localparam int unsigned N_INSN     = 51;
  localparam int unsigned TIMEOUT_NS = (N_INSN * 8 + 50) * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  logic        req_valid;
  logic        req_ready;
  logic [31:0] req_insn;
  logic        resp_valid;
  sum_t        resp_data;

  // Expected response of the pending request, and of the accepted one
  sum_t        req_exp;
  sum_t        exp_resp;
  logic        seen_accept;
  int          accepts;
  int          responses;
  int          errors;
  logic [15:0] lfsr;
  elem_t       ref_regs [NR_VREGS][ELEMS];

  vec_unit UUT (
    .clk_i        (clk       ),
    .rst_n_i      (rst_n     ),
    .req_valid_i  (req_valid ),
    .req_ready_o  (req_ready ),
    .req_insn_i   (req_insn  ),
    .resp_valid_o (resp_valid),
    .resp_data_o  (resp_data )
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Bookkeeping of accepted requests and responses
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seen_accept <= 1'b0;
      exp_resp    <= '0;
      accepts     <= 0;
      responses   <= 0;
    end else begin
      if (req_valid && req_ready) begin
        seen_accept <= 1'b1;
        exp_resp    <= req_exp;
        accepts     <= accepts + 1;
      end
      if (resp_valid) begin
        responses <= responses + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !seen_accept |-> (req_ready && !resp_valid))
    else begin
      errors++;
      $display("error %0t: unit not idle before the first instruction", $time);
    end

  // Busy for five edges, then one response cycle with ready back high
  a_resp_window: assert property (@(posedge clk) disable iff (!rst_n)
    (req_valid && req_ready) |=> (!req_ready && !resp_valid)
      ##1 (!req_ready && !resp_valid) ##1 (!req_ready && !resp_valid)
      ##1 (!req_ready && !resp_valid) ##1 (!req_ready && !resp_valid)
      ##1 (req_ready && resp_valid) ##1 !resp_valid)
    else begin
      errors++;
      $display("error %0t: response window broken after acceptance", $time);
    end

  a_resp_source: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid |-> $past(req_valid && req_ready, 6))
    else begin
      errors++;
      $display("error %0t: response without a matching acceptance", $time);
    end

  a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid |-> (resp_data == exp_resp))
    else begin
      errors++;
      $display("error %0t: response data %0h, expected %0h", $time,
               $sampled(resp_data), $sampled(exp_resp));
    end

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers and register model
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] val;
    logic        out;
    val = '0;
    for (int i = 0; i < n; i++) begin
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out) begin
        lfsr = lfsr ^ 16'hB400;
      end
      val = {val[14:0], out};
    end
    return val;
  endfunction

  function automatic logic [31:0] arith_word(input logic [3:0] op, input logic [2:0] vd,
                                             input logic [2:0] vs1, input logic [2:0] vs2);
    return {op, vd, vs1, vs2, 19'd0};
  endfunction

  function automatic logic [31:0] bcast_word(input logic [2:0] vd, input logic [15:0] imm);
    return {VBCAST, vd, imm, 9'd0};
  endfunction

  // Applies one instruction to the model, returns the expected response
  function automatic sum_t model_exec(input logic [31:0] insn);
    logic [3:0]  op;
    logic [2:0]  vd;
    logic [2:0]  vs1;
    logic [2:0]  vs2;
    logic [15:0] imm;
    sum_t        sum;
    op  = insn[31:28];
    vd  = insn[27:25];
    vs1 = insn[24:22];
    vs2 = insn[21:19];
    imm = insn[24:9];
    sum = '0;
    for (int e = 0; e < ELEMS; e++) begin
      case (op)
        VADD:    ref_regs[vd][e] = ref_regs[vs1][e] + ref_regs[vs2][e];
        VSUB:    ref_regs[vd][e] = ref_regs[vs2][e] - ref_regs[vs1][e];
        VAND:    ref_regs[vd][e] = ref_regs[vs1][e] & ref_regs[vs2][e];
        VXOR:    ref_regs[vd][e] = ref_regs[vs1][e] ^ ref_regs[vs2][e];
        VBCAST:  ref_regs[vd][e] = imm;
        VID:     ref_regs[vd][e] = 16'(e);
        VREDSUM: sum = sum + {4'd0, ref_regs[vs2][e]};
        default: ;
      endcase
    end
    return (op == VREDSUM) ? sum : '0;
  endfunction

  // Holds the request until the unit takes it
  task automatic issue(input logic [31:0] insn);
    req_exp   = model_exec(insn);
    req_insn  = insn;
    req_valid = 1'b1;
    while (!req_ready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic reduce(input logic [2:0] vs2);
    issue(arith_word(VREDSUM, 3'd0, 3'd0, vs2));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req_insn  = '0;
    req_exp   = '0;
    errors    = 0;
    lfsr      = 16'd62;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) @(posedge clk);
    #1;

    // Known contents in every register
    for (int v = 0; v < NR_VREGS; v++) begin
      issue(bcast_word(3'(v), rand_bits(16)));
    end

    // Element index sum, then sixteen times a broadcast
    issue(arith_word(VID, 3'd1, 3'd0, 3'd0));
    reduce(3'd1);
    issue(bcast_word(3'd2, rand_bits(16)));
    reduce(3'd2);
    repeat (3) @(posedge clk);
    #1;

    // Arithmetic that wraps past 16 bits
    issue(bcast_word(3'd2, 16'hFFF8));
    issue(arith_word(VADD, 3'd3, 3'd1, 3'd2));
    reduce(3'd3);
    issue(arith_word(VSUB, 3'd4, 3'd2, 3'd1));
    reduce(3'd4);
    issue(arith_word(VSUB, 3'd5, 3'd1, 3'd2));
    reduce(3'd5);

    // Logic ops on random broadcasts
    repeat (3) begin
      issue(bcast_word(3'd6, rand_bits(16)));
      issue(bcast_word(3'd7, rand_bits(16)));
      issue(arith_word(VAND, 3'd0, 3'd6, 3'd7));
      reduce(3'd0);
      issue(arith_word(VXOR, 3'd5, 3'd1, 3'd6));
      reduce(3'd5);
    end

    // Undefined opcodes must not write
    issue(arith_word(4'h0, 3'd1, 3'd2, 3'd3));
    reduce(3'd1);
    issue(arith_word(4'h8, 3'd3, 3'd4, 3'd5));
    reduce(3'd3);
    issue(arith_word(4'hF, 3'd5, 3'd6, 3'd7));
    reduce(3'd5);

    for (int v = 0; v < NR_VREGS; v++) begin
      reduce(3'(v));
    end

    // Wait for the last response to complete its window
    while (responses != accepts) begin
      @(posedge clk);
      #1;
    end
    repeat (2) @(posedge clk);
    #1;

    assert (responses == N_INSN)
      else begin
        errors++;
        $display("got %0d responses for %0d instructions sent", responses, N_INSN);
      end

    $display("checks done: %0d errors, %0d accepted, %0d responses",
             errors, accepts, responses);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: the unit stopped accepting or answering instructions");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
